/* hdl/servo_ctrl_params.svh */
`ifndef SERVO_CTRL_PARAMS_SVH
`define SERVO_CTRL_PARAMS_SVH

// frame timing, 20 ms at 4 MHz
`define SERVO_FRAME_TICKS    80000
`define SERVO_TICKS_PER_US   4

// pulse limits in us
`define SERVO_CENTER_US      1500
`define SERVO_MIN_US         500
`define SERVO_MAX_US         2500

// move planner
`define SERVO_STARTUP_TICKS  2048
`define SERVO_MIN_RAMP_US    20     // at or below this the move is a jump
`define SERVO_RAMP_STEPS     16

`define SERVO_FIFO_DEPTH     4

`endif

/* hdl/servo_ctrl_pkg.sv */
package servo_ctrl_pkg;

  typedef logic signed [15:0] pulse_us_t;     // pulse width, us
  typedef logic        [15:0] duration_us_t;  // per-step hold, us
  typedef logic        [8:0]  ramp_frac_t;    // fraction of 256

  typedef struct packed {
    pulse_us_t ch1;
    pulse_us_t ch2;
    pulse_us_t ch3;
  } servo_set_t;

  // duration sits in the top word, ch1 below it
  typedef struct packed {
    duration_us_t duration;
    servo_set_t   set;
  } servo_cmd_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [15:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    STARTUP,
    WAIT_CMD,
    LOAD,
    RAMP,
    ARRIVE
  } move_state_t;

endpackage

/* hdl/servo_cmd_wb_slave.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_cmd_wb_slave import servo_ctrl_pkg::*;
(
  input  logic       clk_4mhz,
  input  logic       rst_4mhz,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  output servo_cmd_t cmd,
  output logic       cmd_valid,
  input  logic       cmd_pop
);

  localparam int PTR_W = $clog2(`SERVO_FIFO_DEPTH);

  logic [15:0]      stage_q [4];  // ch1, ch2, ch3 targets, then duration
  logic             ack_q;
  logic [15:0]      rdat_q;
  servo_cmd_t       fifo_mem [`SERVO_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             req;
  logic             push_req;
  logic             full;
  logic             accept;
  logic             push;
  logic             pop;

  // ************************************************************
  // bus side
  // ************************************************************
  assign req      = wb_req.cyc && wb_req.stb && !ack_q;  // no repeat ack on a held stb
  assign push_req = wb_req.we && (wb_req.adr == 2'd3);
  assign full     = (count == (PTR_W + 1)'(`SERVO_FIFO_DEPTH));
  assign accept   = req && !(push_req && full);        // duration write stalls while full
  assign push     = accept && push_req;
  assign pop      = cmd_pop && cmd_valid;

  always_ff @(posedge clk_4mhz)
  begin
    if (rst_4mhz)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= accept;
    end
  end

  always_ff @(posedge clk_4mhz)
  begin
    if (accept)
    begin
      rdat_q <= stage_q[wb_req.adr];  // old word on a write
      if (wb_req.we)
      begin
        stage_q[wb_req.adr] <= wb_req.dat;
      end
    end
    if (push)
    begin
      fifo_mem[wr_ptr] <= '{duration: wb_req.dat,
                            set: '{ch1: stage_q[0], ch2: stage_q[1], ch3: stage_q[2]}};
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};

  // ************************************************************
  // command fifo, show-ahead
  // ************************************************************
  always_ff @(posedge clk_4mhz)
  begin
    if (rst_4mhz)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign cmd       = fifo_mem[rd_ptr];
  assign cmd_valid = (count != '0);

endmodule

/* hdl/servo_move_planner.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_move_planner import servo_ctrl_pkg::*;
(
  input  logic       clk_4mhz,
  input  logic       rst_4mhz,
  input  servo_cmd_t cmd,
  input  logic       cmd_valid,
  output logic       cmd_pop,
  output servo_set_t target
);

  localparam int BOOT_W = $clog2(`SERVO_STARTUP_TICKS) + 1;
  localparam int STEP_W = $clog2(`SERVO_RAMP_STEPS) + 1;
  localparam int TICK_W = 18;  // 16-bit duration times 4

  move_state_t        state_q;
  move_state_t        state_d;
  logic [BOOT_W-1:0]  startup_cnt;
  logic [STEP_W-1:0]  step_idx;
  logic [TICK_W-1:0]  tick_cnt;
  logic [TICK_W-1:0]  step_len;
  duration_us_t       dur_q;
  pulse_us_t          start_q [3];
  logic signed [16:0] diff_q [3];
  pulse_us_t          tgt_q [3];
  pulse_us_t          goal [3];
  pulse_us_t          interp [3];
  ramp_frac_t         frac;
  logic               jump;
  logic               startup_done;
  logic               step_done;

  // raised cosine, (1 - cos(pi*k/16)) / 2 scaled to 256
  function automatic ramp_frac_t ramp_table(input logic [STEP_W-1:0] k);
    case (k)
      5'd0:    return 9'd0;
      5'd1:    return 9'd2;
      5'd2:    return 9'd10;
      5'd3:    return 9'd22;
      5'd4:    return 9'd37;
      5'd5:    return 9'd57;
      5'd6:    return 9'd79;
      5'd7:    return 9'd103;
      5'd8:    return 9'd128;
      5'd9:    return 9'd153;
      5'd10:   return 9'd177;
      5'd11:   return 9'd199;
      5'd12:   return 9'd219;
      5'd13:   return 9'd234;
      5'd14:   return 9'd246;
      5'd15:   return 9'd254;
      default: return 9'd256;
    endcase
  endfunction

  // start + diff*f/256, half rounds up
  function automatic pulse_us_t ramp_point(input pulse_us_t start,
                                           input logic signed [16:0] diff,
                                           input ramp_frac_t f);
    logic signed [26:0] prod;
    prod = diff * $signed({1'b0, f});
    return pulse_us_t'(start + ((prod + 27'sd128) >>> 8));
  endfunction

  assign goal[0] = cmd.set.ch1;
  assign goal[1] = cmd.set.ch2;
  assign goal[2] = cmd.set.ch3;

  assign frac         = ramp_table(step_idx);
  assign step_len     = TICK_W'(dur_q) * TICK_W'(`SERVO_TICKS_PER_US);
  assign step_done    = (tick_cnt == step_len - 1'b1);
  assign startup_done = (startup_cnt == BOOT_W'(`SERVO_STARTUP_TICKS - 1));
  assign jump = (cmd.duration <= `SERVO_MIN_RAMP_US) || cmd.duration[15];
  assign cmd_pop = (state_q == LOAD);  // fifo head is consumed here

  always_comb
  begin
    for (int i = 0; i < 3; i++)
    begin
      interp[i] = ramp_point(start_q[i], diff_q[i], frac);
    end
  end

  // ************************************************************
  // move FSM
  // ************************************************************
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      STARTUP:  state_d = startup_done ? WAIT_CMD : STARTUP;
      WAIT_CMD: state_d = cmd_valid ? LOAD : WAIT_CMD;
      LOAD:     state_d = jump ? ARRIVE : RAMP;
      RAMP:     state_d = (step_done && step_idx == STEP_W'(`SERVO_RAMP_STEPS)) ? ARRIVE : RAMP;
      ARRIVE:   state_d = WAIT_CMD;
      default:  state_d = STARTUP;
    endcase
  end

  always_ff @(posedge clk_4mhz)
  begin
    if (rst_4mhz)
    begin
      state_q     <= STARTUP;
      startup_cnt <= '0;
      step_idx    <= '0;
      tick_cnt    <= '0;
      for (int i = 0; i < 3; i++)
      begin
        tgt_q[i] <= pulse_us_t'(`SERVO_CENTER_US);  // hold centre until first move
      end
    end
    else
    begin
      state_q <= state_d;
      if (state_q == STARTUP)
      begin
        startup_cnt <= startup_cnt + 1'b1;
      end
      if (state_q == LOAD)
      begin
        step_idx <= STEP_W'(1);
        tick_cnt <= '0;
        for (int i = 0; i < 3; i++)
        begin
          if (jump)
          begin
            tgt_q[i] <= goal[i];
          end
        end
      end
      else if (state_q == RAMP)
      begin
        for (int i = 0; i < 3; i++)
        begin
          if (tick_cnt == '0)
          begin
            tgt_q[i] <= interp[i];  // new step point, held step_len cycles
          end
        end
        if (step_done)
        begin
          tick_cnt <= '0;
          step_idx <= step_idx + 1'b1;
        end
        else
        begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
    end
  end

  // move endpoints, taken while the command sits at the fifo head
  always_ff @(posedge clk_4mhz)
  begin
    if (state_q == LOAD)
    begin
      dur_q <= cmd.duration;
      for (int i = 0; i < 3; i++)
      begin
        start_q[i] <= tgt_q[i];
        diff_q[i]  <= goal[i] - tgt_q[i];
      end
    end
  end

  assign target = '{ch1: tgt_q[0], ch2: tgt_q[1], ch3: tgt_q[2]};

endmodule

/* hdl/servo_pwm_out.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_pwm_out import servo_ctrl_pkg::*;
(
  input  logic       clk_4mhz,
  input  logic       rst_4mhz,
  input  servo_set_t target,
  output logic       servo_1,
  output logic       servo_2,
  output logic       servo_3
);

  localparam int CNT_W = $clog2(`SERVO_FRAME_TICKS);
  localparam int LIM_W = CNT_W + 1;

  logic [CNT_W-1:0] frame_cnt;
  logic             frame_wrap;
  pulse_us_t        tgt [3];
  pulse_us_t        width_q [3];
  logic [LIM_W-1:0] limit [3];
  logic [2:0]       pwm_q;

  function automatic pulse_us_t clamp_us(input pulse_us_t v);
    if (v[15] || v < `SERVO_MIN_US)
    begin
      return pulse_us_t'(`SERVO_MIN_US);
    end
    else if (v > `SERVO_MAX_US)
    begin
      return pulse_us_t'(`SERVO_MAX_US);
    end
    return v;
  endfunction

  assign tgt[0] = target.ch1;
  assign tgt[1] = target.ch2;
  assign tgt[2] = target.ch3;

  assign frame_wrap = (frame_cnt == CNT_W'(`SERVO_FRAME_TICKS - 1));

  always_comb
  begin
    for (int i = 0; i < 3; i++)
    begin
      limit[i] = LIM_W'(width_q[i]) * LIM_W'(`SERVO_TICKS_PER_US);  // width in ticks
    end
  end

  // ************************************************************
  // frame counter, width latches, comparators
  // ************************************************************
  always_ff @(posedge clk_4mhz)
  begin
    if (rst_4mhz)
    begin
      frame_cnt <= '0;
      pwm_q     <= '0;
      for (int i = 0; i < 3; i++)
      begin
        width_q[i] <= pulse_us_t'(`SERVO_CENTER_US);
      end
    end
    else
    begin
      frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
      for (int i = 0; i < 3; i++)
      begin
        if (frame_wrap)
        begin
          width_q[i] <= clamp_us(tgt[i]);  // target only sampled at the wrap
        end
        pwm_q[i] <= (LIM_W'(frame_cnt) < limit[i]);  // lags frame_cnt by one cycle
      end
    end
  end

  assign servo_1 = pwm_q[0];
  assign servo_2 = pwm_q[1];
  assign servo_3 = pwm_q[2];

endmodule

/* hdl/servo_ctrl_top.sv */
`timescale 1ns/1ps

module servo_ctrl_top import servo_ctrl_pkg::*;
(
  input  logic    clk_4mhz,
  input  logic    rst_4mhz,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  output logic    servo_1,
  output logic    servo_2,
  output logic    servo_3
);

  servo_cmd_t cmd;        // fifo head
  logic       cmd_valid;
  logic       cmd_pop;
  servo_set_t target;     // planner output, sampled per frame

  servo_cmd_wb_slave servo_cmd_wb_slave_inst (
    .clk_4mhz  (clk_4mhz),
    .rst_4mhz  (rst_4mhz),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_pop   (cmd_pop)
  );

  servo_move_planner servo_move_planner_inst (
    .clk_4mhz  (clk_4mhz),
    .rst_4mhz  (rst_4mhz),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_pop   (cmd_pop),
    .target    (target)
  );

  servo_pwm_out servo_pwm_out_inst (
    .clk_4mhz  (clk_4mhz),
    .rst_4mhz  (rst_4mhz),
    .target    (target),
    .servo_1   (servo_1),
    .servo_2   (servo_2),
    .servo_3   (servo_3)
  );

endmodule

/* verification/servo_ctrl_checker.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_ctrl_checker import servo_ctrl_pkg::*;
(
  input logic        clk_4mhz,
  input logic        rst_4mhz,
  input wb_req_t     wb_req,
  input wb_rsp_t     wb_rsp,
  input logic [16:0] frame_cnt,
  input logic        servo_1,
  input logic        servo_2,
  input logic        servo_3
);

  // outputs lag the frame counter by one cycle
  localparam int PULSE_END = `SERVO_MAX_US * `SERVO_TICKS_PER_US + 1;

  int fail_count = 0;  // assertion failures so far

  ack_single: assert property (@(posedge clk_4mhz) disable iff (rst_4mhz)
    wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
      $error("wishbone ack held for more than one cycle");
      fail_count++;
    end

  ack_answers_request: assert property (@(posedge clk_4mhz) disable iff (rst_4mhz)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else
    begin
      $error("wishbone ack without an active cycle");
      fail_count++;
    end

  pulse_ends_in_time: assert property (@(posedge clk_4mhz) disable iff (rst_4mhz)
    (frame_cnt == 17'(PULSE_END)) |-> !(servo_1 || servo_2 || servo_3))
    else
    begin
      $error("servo line still high past the longest pulse");
      fail_count++;
    end

endmodule

bind servo_ctrl_top servo_ctrl_checker checker_inst (
  .clk_4mhz  (clk_4mhz),
  .rst_4mhz  (rst_4mhz),
  .wb_req    (wb_req),
  .wb_rsp    (wb_rsp),
  .frame_cnt (servo_pwm_out_inst.frame_cnt),
  .servo_1   (servo_1),
  .servo_2   (servo_2),
  .servo_3   (servo_3)
);

/* verification/servo_ctrl_monitor.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_ctrl_monitor
(
  input logic clk_4mhz,
  input logic rst_4mhz,
  input logic servo_1,
  input logic servo_2,
  input logic servo_3,
  input logic cmd_pop
);

  localparam int FRAME_TIMEOUT = `SERVO_FRAME_TICKS + 1000;
  localparam int RAMP_FRAMES   = 10;  // a 5000 us ramp needs about 5
  // raised-cosine points in 1/256 for steps 0 to 16
  localparam int RAMP_FRAC [17] = '{0, 2, 10, 22, 37, 57, 79, 103, 128,
                                    153, 177, 199, 219, 234, 246, 254, 256};

  logic [2:0] line;
  logic [2:0] line_q;
  logic       seen_fall;
  int         high_cnt [3];
  int         width [3];          // last finished pulse in us
  int         frames_done;
  int         pop_count;
  int         pop_mark;
  int         error_count = 0;
  int         errors_at_start;
  int         tests_run = 0;
  int         tests_failed = 0;
  string      test_name;

  assign line = {servo_3, servo_2, servo_1};

  // ************************************************************
  // pulse measurement
  // ************************************************************
  always_ff @(posedge clk_4mhz)
  begin
    if (rst_4mhz)
    begin
      line_q      <= '0;
      seen_fall   <= 1'b0;
      frames_done <= 0;
      pop_count   <= 0;
      for (int i = 0; i < 3; i++)
      begin
        high_cnt[i] <= 0;
        width[i]    <= 0;
      end
    end
    else
    begin
      line_q <= line;
      if (cmd_pop)
      begin
        pop_count <= pop_count + 1;
      end
      for (int i = 0; i < 3; i++)
      begin
        if (line[i])
        begin
          high_cnt[i] <= high_cnt[i] + 1;
        end
        else if (line_q[i])
        begin
          width[i]    <= high_cnt[i] / `SERVO_TICKS_PER_US;  // falling edge
          high_cnt[i] <= 0;
          seen_fall   <= 1'b1;
        end
      end
      if (line[0] && !line_q[0] && seen_fall)
      begin
        frames_done <= frames_done + 1;  // previous frame fully measured
      end
    end
  end

  // ************************************************************
  // reference model
  // ************************************************************
  function automatic int clamp_word(input logic [15:0] w);
    if (w[15] || w < `SERVO_MIN_US)
    begin
      return `SERVO_MIN_US;
    end
    if (w > `SERVO_MAX_US)
    begin
      return `SERVO_MAX_US;
    end
    return int'(w);
  endfunction

  // width at ramp step k with half rounded up
  function automatic int expected_width(input logic [15:0] start, input logic [15:0] goal,
                                        input int k);
    int s;
    int g;
    int p;
    s = int'($signed(start));
    g = int'($signed(goal));
    p = s + (((g - s) * RAMP_FRAC[k] + 128) >>> 8);
    return clamp_word(16'(p));
  endfunction

  task automatic record_failure(input string what);
    $display("%s (test %s)", what, test_name);
    error_count++;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count == errors_at_start)
    begin
      $display("test %s: passed", test_name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  task automatic print_summary(input int assertion_failures);
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, error_count, assertion_failures);
  endtask

  task automatic wait_frame();
    int start_count;
    int t;
    start_count = frames_done;
    t = 0;
    while (frames_done == start_count && t < FRAME_TIMEOUT)
    begin
      @(posedge clk_4mhz);
      #1;
      t++;
    end
    if (frames_done == start_count)
    begin
      record_failure("no servo frame finished within the timeout");
    end
  endtask

  task automatic skip_frames(input int n);
    repeat (n)
    begin
      wait_frame();
    end
  endtask

  task automatic compare_width(input int ch, input int expected);
    if (width[ch] != expected)
    begin
      $display("Error: servo_%0d expected 0x%04h actual 0x%04h (test %s)",
               ch + 1, 16'(expected), 16'(width[ch]), test_name);
      error_count++;
    end
  endtask

  task automatic compare_word(input int adr, input logic [15:0] expected,
                              input logic [15:0] actual);
    if (actual !== expected)
    begin
      $display("Error: wb_rsp.dat at address %0d expected 0x%04h actual 0x%04h (test %s)",
               adr, expected, actual, test_name);
      error_count++;
    end
  endtask

  task automatic check_frames(input int n, input logic [15:0] t1, input logic [15:0] t2,
                              input logic [15:0] t3);
    repeat (n)
    begin
      wait_frame();
      compare_width(0, expected_width(t1, t1, `SERVO_RAMP_STEPS));
      compare_width(1, expected_width(t2, t2, `SERVO_RAMP_STEPS));
      compare_width(2, expected_width(t3, t3, `SERVO_RAMP_STEPS));
    end
  endtask

  // each frame must sit on a ramp step at or after the last one seen
  task automatic check_ramp(input logic [15:0] s1, s2, s3, g1, g2, g3);
    logic [15:0] s [3];
    logic [15:0] g [3];
    int          k;
    int          frames;
    bit          on_ramp;
    s       = '{s1, s2, s3};
    g       = '{g1, g2, g3};
    k       = 0;
    frames  = 0;
    on_ramp = 1'b1;
    while (k < `SERVO_RAMP_STEPS && frames < RAMP_FRAMES && on_ramp)
    begin
      wait_frame();
      frames++;
      on_ramp = 1'b0;
      for (int j = k; j <= `SERVO_RAMP_STEPS && !on_ramp; j++)
      begin
        if (width[0] == expected_width(s[0], g[0], j) &&
            width[1] == expected_width(s[1], g[1], j) &&
            width[2] == expected_width(s[2], g[2], j))
        begin
          on_ramp = 1'b1;
          k       = j;
        end
      end
      if (!on_ramp)
      begin
        $display("Error: servo_1/2/3 widths 0x%04h 0x%04h 0x%04h off the ramp (test %s)",
                 16'(width[0]), 16'(width[1]), 16'(width[2]), test_name);
        error_count++;
      end
    end
    for (int i = 0; i < 3; i++)
    begin
      compare_width(i, expected_width(s[i], g[i], `SERVO_RAMP_STEPS));
    end
  endtask

  task automatic mark_pops();
    pop_mark = pop_count;
  endtask

  task automatic require_pop();
    if (pop_count == pop_mark)
    begin
      record_failure("last push was acked before the first queued command left the FIFO");
    end
  endtask

endmodule

/* verification/servo_ctrl_tb.sv */
`timescale 1ns/1ps
`include "servo_ctrl_params.svh"

module servo_ctrl_tb import servo_ctrl_pkg::*; ();

  localparam int ACK_TIMEOUT = 4 * `SERVO_FRAME_TICKS;  // a push may wait behind a whole move

  logic        clk_4mhz;
  logic        rst_4mhz;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        servo_1;
  logic        servo_2;
  logic        servo_3;
  integer      seed;
  logic [15:0] written [4];  // last word written per address
  logic [15:0] rdata;
  logic [15:0] tgt [3];

  servo_ctrl_top servo_ctrl_top_inst (
    .clk_4mhz (clk_4mhz),
    .rst_4mhz (rst_4mhz),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .servo_1  (servo_1),
    .servo_2  (servo_2),
    .servo_3  (servo_3)
  );

  servo_ctrl_monitor monitor_inst (
    .clk_4mhz (clk_4mhz),
    .rst_4mhz (rst_4mhz),
    .servo_1  (servo_1),
    .servo_2  (servo_2),
    .servo_3  (servo_3),
    .cmd_pop  (servo_ctrl_top_inst.cmd_pop)
  );

  initial
  begin
    clk_4mhz = 1'b0;
    forever
    begin
      #2 clk_4mhz = ~clk_4mhz;
    end
  end

  // ************************************************************
  // wishbone host
  // ************************************************************
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                           output logic [15:0] rd);
    int   t;
    logic got_ack;
    wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    t       = 0;
    got_ack = 1'b0;
    while (!got_ack && t < ACK_TIMEOUT)
    begin
      @(posedge clk_4mhz);
      #1;
      t++;
      got_ack = wb_rsp.ack;
    end
    rd = wb_rsp.dat;
    if (!got_ack)
    begin
      monitor_inst.record_failure($sformatf("no ack within %0d cycles at address %0d",
                                            ACK_TIMEOUT, adr));
    end
    wb_req = '0;  // drop cyc and stb after the ack
  endtask

  task automatic write_word(input logic [1:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
    written[adr] = dat;
  endtask

  task automatic read_word(input logic [1:0] adr, output logic [15:0] dat);
    bus_cycle(1'b0, adr, 16'h0000, dat);
  endtask

  task automatic send_command(input logic [15:0] dur, input logic [15:0] t1,
                              input logic [15:0] t2, input logic [15:0] t3);
    write_word(2'd0, t1);
    write_word(2'd1, t2);
    write_word(2'd2, t3);
    write_word(2'd3, dur);  // push
  endtask

  function automatic logic [15:0] random_target();
    return 16'(`SERVO_MIN_US + ({$random(seed)} % (`SERVO_MAX_US - `SERVO_MIN_US + 1)));
  endfunction

  // ************************************************************
  // test sequence
  // ************************************************************
  initial
  begin
    seed     = 32'he71b6306;
    rst_4mhz = 1'b1;
    wb_req   = '0;
    repeat (16)
    begin
      @(posedge clk_4mhz);
    end
    #1;
    rst_4mhz = 1'b0;

    monitor_inst.start_test("startup");
    monitor_inst.check_frames(2, 16'd1500, 16'd1500, 16'd1500);
    monitor_inst.finish_test();

    monitor_inst.start_test("direct jump");
    for (int i = 0; i < 3; i++)
    begin
      tgt[i] = random_target();
    end
    send_command(16'd10, tgt[0], tgt[1], tgt[2]);
    monitor_inst.skip_frames(2);  // frame of the ack and the one after
    monitor_inst.check_frames(2, tgt[0], tgt[1], tgt[2]);
    monitor_inst.finish_test();

    monitor_inst.start_test("clamp");
    send_command(16'd10, 16'd3000, 16'd100, 16'h8123);
    monitor_inst.skip_frames(2);
    monitor_inst.check_frames(2, 16'd3000, 16'd100, 16'h8123);
    monitor_inst.finish_test();

    monitor_inst.start_test("ramp");
    send_command(16'd10, 16'd1000, 16'd2000, 16'd1200);  // known start point
    monitor_inst.skip_frames(2);
    send_command(16'd5000, 16'd2400, 16'd600, 16'd1800);
    monitor_inst.check_ramp(16'd1000, 16'd2000, 16'd1200, 16'd2400, 16'd600, 16'd1800);
    monitor_inst.finish_test();

    monitor_inst.start_test("back-pressure");
    monitor_inst.mark_pops();
    for (int n = 0; n < 4; n++)
    begin
      send_command(16'd25, 16'(800 + 100 * n), 16'(2200 - 100 * n), 16'(1200 + 50 * n));
    end
    for (int i = 0; i < 3; i++)
    begin
      tgt[i] = random_target();
    end
    send_command(16'd10, tgt[0], tgt[1], tgt[2]);
    monitor_inst.require_pop();
    monitor_inst.skip_frames(2);
    monitor_inst.check_frames(2, tgt[0], tgt[1], tgt[2]);
    monitor_inst.finish_test();

    monitor_inst.start_test("readback");
    for (int a = 0; a < 4; a++)
    begin
      read_word(2'(a), rdata);
      monitor_inst.compare_word(a, written[a], rdata);
    end
    monitor_inst.finish_test();

    monitor_inst.print_summary(servo_ctrl_top_inst.checker_inst.fail_count);
    if (monitor_inst.error_count == 0 && servo_ctrl_top_inst.checker_inst.fail_count == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* servo_ctrl_top.f */
+incdir+hdl
hdl/servo_ctrl_pkg.sv
hdl/servo_cmd_wb_slave.sv
hdl/servo_move_planner.sv
hdl/servo_pwm_out.sv
hdl/servo_ctrl_top.sv
verification/servo_ctrl_checker.sv
verification/servo_ctrl_monitor.sv
verification/servo_ctrl_tb.sv

/* Bender.yml */
package:
  name: servo_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/servo_ctrl_pkg.sv
      - hdl/servo_cmd_wb_slave.sv
      - hdl/servo_move_planner.sv
      - hdl/servo_pwm_out.sv
      - hdl/servo_ctrl_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/servo_ctrl_checker.sv
      - verification/servo_ctrl_monitor.sv
      - verification/servo_ctrl_tb.sv
